/* Bender.yml */
package:
  name: hand_tracker

sources:
  - logic/hand_tracker_pkg.sv
  - logic/raster_timing.sv
  - logic/ycrcb_convert.sv
  - logic/chroma_threshold.sv
  - logic/center_of_mass.sv
  - logic/hand_position_collector.sv
  - logic/hand_tracker_top.sv
  - target: test
    files:
      - tests/hand_tracker_checker.sv
      - tests/hand_tracker_assertions.sv
      - tests/hand_tracker_tb.sv

/* hand_tracker_top.f */
logic/hand_tracker_pkg.sv
logic/raster_timing.sv
logic/ycrcb_convert.sv
logic/chroma_threshold.sv
logic/center_of_mass.sv
logic/hand_position_collector.sv
logic/hand_tracker_top.sv
tests/hand_tracker_checker.sv
tests/hand_tracker_assertions.sv
tests/hand_tracker_tb.sv

/* logic/center_of_mass.sv */
`timescale 1ns/1ps

module center_of_mass import hand_tracker_pkg::*; (
  input logic clk_65mhz,
  input logic sys_rst,
  input logic mark,
  input scan_pos_t pos,
  output com_result_t com,
  output logic com_valid
);

  // remainder on top, dividend shifting into quotient below
  localparam int DIV_W = COM_CNT_W + COM_SUM_W;
  localparam int STEP_W = $clog2(COM_SUM_W);

  logic [COM_SUM_W-1:0] sum_x, sum_y;
  logic [COM_CNT_W-1:0] count;
  logic [COM_SUM_W-1:0] tot_x, tot_y;
  logic [COM_CNT_W-1:0] tot_cnt;
  logic start;
  div_state_e state;
  logic [STEP_W-1:0] step;
  logic [COM_CNT_W-1:0] divisor;
  logic [DIV_W-1:0] div_x, div_y;

  // one restoring step
  function automatic logic [DIV_W-1:0] div_step(
    input logic [DIV_W-1:0] acc,
    input logic [COM_CNT_W-1:0] d
  );
    logic [COM_CNT_W:0] trial;
    logic [COM_CNT_W:0] diff;
    trial = {acc[DIV_W-1:COM_SUM_W], acc[COM_SUM_W-1]};
    diff = trial - {1'b0, d};
    if (trial >= {1'b0, d}) begin
      return {diff[COM_CNT_W-1:0], acc[COM_SUM_W-2:0], 1'b1};
    end
    return {trial[COM_CNT_W-1:0], acc[COM_SUM_W-2:0], 1'b0};
  endfunction

  // running totals including the current position
  always_comb begin
    tot_x = sum_x + (mark ? COM_SUM_W'(pos.hcount) : '0);
    tot_y = sum_y + (mark ? COM_SUM_W'(pos.vcount) : '0);
    tot_cnt = count + COM_CNT_W'(mark);
  end

  // empty frames never start the divider
  assign start = pos.frame_end && (tot_cnt != '0);

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
      state <= DIV_IDLE;
      step <= '0;
      com_valid <= 1'b0;
    end else begin
      com_valid <= 1'b0;
      // next frame accumulates from scratch right away
      if (pos.frame_end) begin
        sum_x <= '0;
        sum_y <= '0;
        count <= '0;
      end else begin
        sum_x <= tot_x;
        sum_y <= tot_y;
        count <= tot_cnt;
      end
      if (start) begin
        state <= DIV_RUN;
        step <= '0;
      end else if (state == DIV_RUN) begin
        step <= step + 1'b1;
        // 32 steps, pulse lands 33 cycles after frame_end at the input
        if (step == STEP_W'(COM_SUM_W - 1)) begin
          state <= DIV_IDLE;
          com_valid <= 1'b1;
        end
      end
    end
  end

  // both axes share the divisor and step in parallel
  always_ff @(posedge clk_65mhz) begin
    if (start) begin
      divisor <= tot_cnt;
      div_x <= {COM_CNT_W'(0), tot_x};
      div_y <= {COM_CNT_W'(0), tot_y};
    end else if (state == DIV_RUN) begin
      div_x <= div_step(div_x, divisor);
      div_y <= div_step(div_y, divisor);
    end
  end

  // quotients, mean always fits the scan widths
  assign com.x = div_x[$bits(hcount_t)-1:0];
  assign com.y = div_y[$bits(vcount_t)-1:0];

endmodule

/* logic/chroma_threshold.sv */
`timescale 1ns/1ps

module chroma_threshold import hand_tracker_pkg::*; (
  input logic clk_65mhz,
  input ycrcb_t color,
  input scan_pos_t pos_in,
  input chroma_bounds_t bounds,
  output logic [N_TRACKERS-1:0] mask,
  output scan_pos_t pos_out
);

  logic cr_hit;
  logic cb_hit;

  // only the top nibble of each chroma channel is compared
  assign cr_hit = (color.cr[9:6] >= bounds.cr_min);
  assign cb_hit = (color.cb[9:6] >= bounds.cb_min);

  // mask and position leave together
  always_ff @(posedge clk_65mhz) begin
    // red glove
    mask[TRACK_CR] <= pos_in.active && cr_hit;
    // blue glove
    mask[TRACK_CB] <= pos_in.active && cb_hit;
    pos_out <= pos_in;
  end

endmodule

/* logic/hand_position_collector.sv */
`timescale 1ns/1ps

module hand_position_collector import hand_tracker_pkg::*; (
  input logic clk_65mhz,
  input logic sys_rst,
  input com_result_t com [N_TRACKERS],
  input logic [N_TRACKERS-1:0] com_valid,
  output hand_position_t hands [N_TRACKERS],
  output logic transmit_xy_update
);

  logic [N_TRACKERS-1:0] pending;
  hand_position_t staged [N_TRACKERS];
  logic all_in;

  // x and y trade places for the rotated camera
  function automatic hand_position_t swap_axes(input com_result_t c);
    hand_position_t h;
    h.hand_x = 12'(c.y);
    h.hand_y = 12'(c.x);
    return h;
  endfunction

  // every tracker reported, either earlier or in this cycle
  assign all_in = &(pending | com_valid);

  // newest result per tracker, a repeat just overwrites
  always_ff @(posedge clk_65mhz) begin
    for (int i = 0; i < N_TRACKERS; i++) begin
      if (com_valid[i]) begin
        staged[i] <= swap_axes(com[i]);
      end
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      pending <= '0;
      transmit_xy_update <= 1'b0;
      for (int i = 0; i < N_TRACKERS; i++) begin
        hands[i] <= '0;
      end
    end else begin
      transmit_xy_update <= all_in;
      if (all_in) begin
        // publish and start collecting again
        pending <= '0;
        for (int i = 0; i < N_TRACKERS; i++) begin
          hands[i] <= com_valid[i] ? swap_axes(com[i]) : staged[i];
        end
      end else begin
        pending <= pending | com_valid;
      end
    end
  end

endmodule

/* logic/hand_tracker_pkg.sv */
package hand_tracker_pkg;

  // scan position widths
  typedef logic [10:0] hcount_t;
  typedef logic [9:0] vcount_t;

  // one raster position plus its flags
  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
    logic active;
    logic frame_end;
  } scan_pos_t;

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef struct packed {
    logic [9:0] y;
    logic [9:0] cr;
    logic [9:0] cb;
  } ycrcb_t;

  // compared against cr[9:6] and cb[9:6]
  typedef struct packed {
    logic [3:0] cr_min;
    logic [3:0] cb_min;
  } chroma_bounds_t;

  // tracker index, also the hand index
  typedef enum logic [0:0] {
    TRACK_CR = 1'b0,
    TRACK_CB = 1'b1
  } tracker_id_e;

  localparam int N_TRACKERS = 2;

  typedef struct packed {
    hcount_t x;
    vcount_t y;
  } com_result_t;

  // camera sits rotated, so hand_x comes from the tracker's y
  typedef struct packed {
    logic [11:0] hand_x;
    logic [11:0] hand_y;
  } hand_position_t;

  typedef enum logic {
    DIV_IDLE,
    DIV_RUN
  } div_state_e;

  // accumulator widths, sized for a 1024x768 frame
  localparam int COM_SUM_W = 32;
  localparam int COM_CNT_W = 20;

  // bt.601, scaled by 256
  localparam logic [7:0] YCRCB_COEF_Y_R = 8'd77;
  localparam logic [7:0] YCRCB_COEF_Y_G = 8'd150;
  localparam logic [7:0] YCRCB_COEF_Y_B = 8'd29;
  localparam logic [7:0] YCRCB_COEF_CR_R = 8'd128;
  localparam logic [7:0] YCRCB_COEF_CR_G = 8'd107;
  localparam logic [7:0] YCRCB_COEF_CR_B = 8'd21;
  localparam logic [7:0] YCRCB_COEF_CB_R = 8'd43;
  localparam logic [7:0] YCRCB_COEF_CB_G = 8'd85;
  localparam logic [7:0] YCRCB_COEF_CB_B = 8'd128;
  // chroma midpoint 512, already scaled by 256
  localparam logic signed [19:0] YCRCB_CHROMA_OFS = 20'sd131072;

endpackage

/* logic/hand_tracker_top.sv */
`timescale 1ns/1ps

module hand_tracker_top import hand_tracker_pkg::*; #(
  parameter int H_ACTIVE = 1024,
  parameter int V_ACTIVE = 768,
  parameter int H_TOTAL = 1344,
  parameter int V_TOTAL = 806
) (
  input logic clk_65mhz,
  input logic sys_rst,
  input rgb565_t pixel,
  input chroma_bounds_t bounds,
  output scan_pos_t scan_pos,
  output hand_position_t hands [N_TRACKERS],
  output logic transmit_xy_update
);

  ycrcb_t color;
  scan_pos_t conv_pos;
  logic [N_TRACKERS-1:0] mask;
  scan_pos_t thr_pos;
  com_result_t com [N_TRACKERS];
  logic [N_TRACKERS-1:0] com_valid;

  // raster source, pixel comes back in the same cycle
  raster_timing #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE),
    .H_TOTAL(H_TOTAL),
    .V_TOTAL(V_TOTAL)
  ) u_raster (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .scan_pos(scan_pos)
  );

  // 3 cycles
  ycrcb_convert u_convert (
    .clk_65mhz(clk_65mhz),
    .pixel(pixel),
    .pos_in(scan_pos),
    .color(color),
    .pos_out(conv_pos)
  );

  // 1 cycle
  chroma_threshold u_threshold (
    .clk_65mhz(clk_65mhz),
    .color(color),
    .pos_in(conv_pos),
    .bounds(bounds),
    .mask(mask),
    .pos_out(thr_pos)
  );

  // one tracker per mask bit
  for (genvar i = 0; i < N_TRACKERS; i++) begin : g_tracker
    center_of_mass u_com (
      .clk_65mhz(clk_65mhz),
      .sys_rst(sys_rst),
      .mark(mask[i]),
      .pos(thr_pos),
      .com(com[i]),
      .com_valid(com_valid[i])
    );
  end

  hand_position_collector u_collector (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .com(com),
    .com_valid(com_valid),
    .hands(hands),
    .transmit_xy_update(transmit_xy_update)
  );

endmodule

/* logic/raster_timing.sv */
`timescale 1ns/1ps

module raster_timing import hand_tracker_pkg::*; #(
  parameter int H_ACTIVE = 1024,
  parameter int V_ACTIVE = 768,
  parameter int H_TOTAL = 1344,
  parameter int V_TOTAL = 806
) (
  input logic clk_65mhz,
  input logic sys_rst,
  output scan_pos_t scan_pos
);

  hcount_t h_next;
  vcount_t v_next;
  logic line_end;
  logic frame_wrap;

  // next position, wrapping at the totals
  always_comb begin
    line_end = (scan_pos.hcount == hcount_t'(H_TOTAL - 1));
    frame_wrap = (scan_pos.vcount == vcount_t'(V_TOTAL - 1));
    if (line_end) begin
      h_next = '0;
    end else begin
      h_next = scan_pos.hcount + 1'b1;
    end
    if (!line_end) begin
      v_next = scan_pos.vcount;
    end else if (frame_wrap) begin
      v_next = '0;
    end else begin
      v_next = scan_pos.vcount + 1'b1;
    end
  end

  // flags are formed from the next position so they line up
  // with the registered counters
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      // parked at 0,0 and inactive
      scan_pos <= '0;
    end else begin
      scan_pos.hcount <= h_next;
      scan_pos.vcount <= v_next;
      scan_pos.active <= (h_next < hcount_t'(H_ACTIVE)) &&
                         (v_next < vcount_t'(V_ACTIVE));
      // last visible pixel of the frame
      scan_pos.frame_end <= (h_next == hcount_t'(H_ACTIVE - 1)) &&
                            (v_next == vcount_t'(V_ACTIVE - 1));
    end
  end

endmodule

/* logic/ycrcb_convert.sv */
`timescale 1ns/1ps

module ycrcb_convert import hand_tracker_pkg::*; (
  input logic clk_65mhz,
  input rgb565_t pixel,
  input scan_pos_t pos_in,
  output ycrcb_t color,
  output scan_pos_t pos_out
);

  logic [9:0] r10, g10, b10;
  // stage 1 products
  logic [17:0] p_y_r, p_y_g, p_y_b;
  logic [17:0] p_cr_r, p_cr_g, p_cr_b;
  logic [17:0] p_cb_r, p_cb_g, p_cb_b;
  // stage 2 sums
  logic [18:0] y_sum;
  logic signed [19:0] cr_diff, cb_diff;
  logic signed [19:0] cr_ofs, cb_ofs;
  // position travels with the data
  scan_pos_t pos_d1, pos_d2;

  // msb replication so full scale maps to 1023
  assign r10 = {pixel.r, pixel.r};
  assign g10 = {pixel.g, pixel.g[5:2]};
  assign b10 = {pixel.b, pixel.b};

  // multiply
  always_ff @(posedge clk_65mhz) begin
    p_y_r <= r10 * YCRCB_COEF_Y_R;
    p_y_g <= g10 * YCRCB_COEF_Y_G;
    p_y_b <= b10 * YCRCB_COEF_Y_B;
    p_cr_r <= r10 * YCRCB_COEF_CR_R;
    p_cr_g <= g10 * YCRCB_COEF_CR_G;
    p_cr_b <= b10 * YCRCB_COEF_CR_B;
    p_cb_r <= r10 * YCRCB_COEF_CB_R;
    p_cb_g <= g10 * YCRCB_COEF_CB_G;
    p_cb_b <= b10 * YCRCB_COEF_CB_B;
    pos_d1 <= pos_in;
  end

  // sum, chroma goes signed here
  always_ff @(posedge clk_65mhz) begin
    y_sum <= p_y_r + p_y_g + p_y_b;
    cr_diff <= signed'({2'b00, p_cr_r}) - signed'({2'b00, p_cr_g}) -
               signed'({2'b00, p_cr_b});
    cb_diff <= signed'({2'b00, p_cb_b}) - signed'({2'b00, p_cb_r}) -
               signed'({2'b00, p_cb_g});
    pos_d2 <= pos_d1;
  end

  // offset back to unsigned, range is 0..1023 after the shift
  assign cr_ofs = cr_diff + YCRCB_CHROMA_OFS;
  assign cb_ofs = cb_diff + YCRCB_CHROMA_OFS;

  always_ff @(posedge clk_65mhz) begin
    color.y <= y_sum[17:8];
    color.cr <= cr_ofs[17:8];
    color.cb <= cb_ofs[17:8];
    pos_out <= pos_d2;
  end

endmodule

/* tests/hand_tracker_assertions.sv */
`timescale 1ns/1ps

module hand_tracker_assertions import hand_tracker_pkg::*; (
  input logic clk_65mhz,
  input logic sys_rst,
  input logic [N_TRACKERS-1:0] com_valid,
  input hand_position_t hands [N_TRACKERS],
  input logic transmit_xy_update
);

  localparam int HW = $bits(hand_position_t);

  int assert_fails = 0;
  logic [N_TRACKERS*HW-1:0] hands_flat;

  // packed copy of all hands
  always_comb begin
    for (int i = 0; i < N_TRACKERS; i++) begin
      hands_flat[i*HW +: HW] = hands[i];
    end
  end

  // strobe lasts one cycle
  a_single_cycle: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    transmit_xy_update |=> !transmit_xy_update)
    else begin
      assert_fails++;
      $error("transmit_xy_update high for two cycles in a row");
    end

  // quiet while held in reset
  a_reset_quiet: assert property (@(posedge clk_65mhz)
    sys_rst && $past(sys_rst) |-> !transmit_xy_update)
    else begin
      assert_fails++;
      $error("transmit_xy_update high during reset");
    end

  // hands only move with the strobe or right after a tracker result
  a_hands_update: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    !$stable(hands_flat) |-> transmit_xy_update || $past(|com_valid))
    else begin
      assert_fails++;
      $error("hands changed without a transmit or tracker result");
    end

endmodule

bind hand_position_collector hand_tracker_assertions u_assertions (
  .clk_65mhz(clk_65mhz),
  .sys_rst(sys_rst),
  .com_valid(com_valid),
  .hands(hands),
  .transmit_xy_update(transmit_xy_update)
);

/* tests/hand_tracker_checker.sv */
`timescale 1ns/1ps

module hand_tracker_checker import hand_tracker_pkg::*; #(
  parameter int H_ACTIVE = 32,
  parameter int V_ACTIVE = 24,
  parameter int H_TOTAL = 40,
  parameter int V_TOTAL = 28
) (
  input logic clk_65mhz,
  input logic sys_rst,
  input scan_pos_t scan_pos,
  input hand_position_t hands [N_TRACKERS],
  input logic transmit_xy_update
);

  string test_name = "none";
  hand_position_t expected [N_TRACKERS];
  int expected_pulses = 0;
  int pulses = 0;
  int errors = 0;
  int checks = 0;
  // raster model, one step per clock out of reset
  int exp_h = 0;
  int exp_v = 0;
  scan_pos_t exp_pos;
  logic rst_at_edge = 1'b1;

  // both hands against the current frame's expectation
  task automatic compare_hands(input string when_seen);
    for (int i = 0; i < N_TRACKERS; i++) begin
      checks++;
      if (hands[i] !== expected[i]) begin
        errors++;
        $display("[FAIL] %s %s hands[%0d] expected %h actual %h",
                 test_name, when_seen, i, expected[i], hands[i]);
      end
    end
  endtask

  // new frame window, pulse count restarts
  task automatic begin_frame(input string name, input hand_position_t exp_cr,
                             input hand_position_t exp_cb, input int exp_pulses);
    test_name = name;
    expected[TRACK_CR] = exp_cr;
    expected[TRACK_CB] = exp_cb;
    expected_pulses = exp_pulses;
    pulses = 0;
  endtask

  // pulse count for the frame, and hands held after it
  task automatic end_frame();
    checks++;
    if (pulses != expected_pulses) begin
      errors++;
      $display("[FAIL] %s transmit pulses expected %0d actual %0d",
               test_name, expected_pulses, pulses);
    end
    compare_hands("after frame");
  endtask

  // reset level as the DUT saw it on the last rising edge
  always @(posedge clk_65mhz) begin
    rst_at_edge <= sys_rst;
  end

  // outputs settle on the rising edge, so look on the falling one
  always @(negedge clk_65mhz) begin
    if (!sys_rst && transmit_xy_update) begin
      pulses++;
      compare_hands("at pulse");
    end
  end

  // scan position walks the raster, parked at 0,0 in reset
  always @(negedge clk_65mhz) begin
    checks++;
    if (rst_at_edge) begin
      exp_h = 0;
      exp_v = 0;
      if (scan_pos.hcount !== '0 || scan_pos.vcount !== '0) begin
        errors++;
        $display("[FAIL] %s scan_pos in reset expected 0,0 actual %0d,%0d",
                 test_name, scan_pos.hcount, scan_pos.vcount);
      end
    end else begin
      exp_h = (exp_h + 1) % H_TOTAL;
      if (exp_h == 0) begin
        exp_v = (exp_v + 1) % V_TOTAL;
      end
      exp_pos.hcount = hcount_t'(exp_h);
      exp_pos.vcount = vcount_t'(exp_v);
      exp_pos.active = (exp_h < H_ACTIVE) && (exp_v < V_ACTIVE);
      // last visible position
      exp_pos.frame_end = (exp_h == H_ACTIVE - 1) && (exp_v == V_ACTIVE - 1);
      if (scan_pos !== exp_pos) begin
        errors++;
        $display("[FAIL] %s scan_pos expected %h actual %h",
                 test_name, exp_pos, scan_pos);
      end
    end
  end

endmodule

/* tests/hand_tracker_tb.sv */
`timescale 1ns/1ps

module hand_tracker_tb import hand_tracker_pkg::*; ();

  // small raster keeps a frame at 1120 cycles
  localparam int H_ACTIVE = 32;
  localparam int V_ACTIVE = 24;
  localparam int H_TOTAL = 40;
  localparam int V_TOTAL = 28;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int START_TIMEOUT = 2 * FRAME_CYCLES;

  logic clk_65mhz = 1'b0;
  logic sys_rst;
  rgb565_t pixel;
  chroma_bounds_t bounds;
  scan_pos_t scan_pos;
  hand_position_t hands [N_TRACKERS];
  logic transmit_xy_update;

  // index 0 red, index 1 blue; corners x0 y0 x1 y1
  int rect [2][4];
  rgb565_t rect_color [2];
  logic [31:0] lcg_state = 32'hb87e;
  bit aborted = 0;

  always #5 clk_65mhz = ~clk_65mhz;

  hand_tracker_top #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE),
    .H_TOTAL(H_TOTAL),
    .V_TOTAL(V_TOTAL)
  ) DUT (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .pixel(pixel),
    .bounds(bounds),
    .scan_pos(scan_pos),
    .hands(hands),
    .transmit_xy_update(transmit_xy_update)
  );

  hand_tracker_checker #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE),
    .H_TOTAL(H_TOTAL),
    .V_TOTAL(V_TOTAL)
  ) chk (
    .clk_65mhz(clk_65mhz),
    .sys_rst(sys_rst),
    .scan_pos(scan_pos),
    .hands(hands),
    .transmit_xy_update(transmit_xy_update)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic in_rect(input int k, input int h, input int v);
    return h >= rect[k][0] && h <= rect[k][2] && v >= rect[k][1] && v <= rect[k][3];
  endfunction

  // pixel for the position shown in this cycle
  task automatic drive_pixel();
    if (in_rect(0, scan_pos.hcount, scan_pos.vcount)) begin
      pixel = rect_color[0];
    end else if (in_rect(1, scan_pos.hcount, scan_pos.vcount)) begin
      pixel = rect_color[1];
    end else begin
      // dark noise, chroma stays near the midpoint
      lcg_state = lcg_next(lcg_state);
      pixel.r = {3'b000, lcg_state[17:16]};
      pixel.g = {4'b0000, lcg_state[19:18]};
      pixel.b = {3'b000, lcg_state[21:20]};
    end
  endtask

  task automatic wait_frame_start();
    int waited;
    waited = 0;
    while (!(scan_pos.hcount == 0 && scan_pos.vcount == 0) && waited < START_TIMEOUT) begin
      @(posedge clk_65mhz);
      #1;
      waited++;
    end
    if (waited >= START_TIMEOUT) begin
      $display("timeout: no frame start within %0d cycles", START_TIMEOUT);
      aborted = 1;
    end
  endtask

  // one full frame, results land in its blanking
  task automatic run_frame();
    for (int c = 0; c < FRAME_CYCLES; c++) begin
      drive_pixel();
      @(posedge clk_65mhz);
      #1;
    end
  endtask

  initial begin
    int fd;
    int n;
    int frames;
    int cr_min;
    int cb_min;
    int exp_pulses;
    int hx [N_TRACKERS];
    int hy [N_TRACKERS];
    string line;
    string name;
    hand_position_t exp_cr;
    hand_position_t exp_cb;
    frames = 0;
    sys_rst = 1'b1;
    pixel = '0;
    bounds = '0;
    repeat (4) @(posedge clk_65mhz);
    #1;
    sys_rst = 1'b0;
    fd = $fopen("tests/hand_tracker_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/hand_tracker_tests.txt");
      aborted = 1;
    end
    while (!aborted && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n != 0 && line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %d %d %h %d %d %d %d %h %d %d %d %d %d %d %d %d %d",
                    name, cr_min, cb_min, rect_color[0], rect[0][0], rect[0][1],
                    rect[0][2], rect[0][3], rect_color[1], rect[1][0], rect[1][1],
                    rect[1][2], rect[1][3], hx[0], hy[0], hx[1], hy[1], exp_pulses);
        if (n != 18) begin
          $display("malformed test line: %s", line);
          aborted = 1;
        end else begin
          wait_frame_start();
          if (!aborted) begin
            bounds.cr_min = 4'(cr_min);
            bounds.cb_min = 4'(cb_min);
            exp_cr.hand_x = 12'(hx[0]);
            exp_cr.hand_y = 12'(hy[0]);
            exp_cb.hand_x = 12'(hx[1]);
            exp_cb.hand_y = 12'(hy[1]);
            chk.begin_frame(name, exp_cr, exp_cb, exp_pulses);
            run_frame();
            chk.end_frame();
            frames++;
          end
        end
      end
    end
    $display("summary: %0d frames, %0d checks, %0d check errors, %0d assertion errors",
             frames, chk.checks, chk.errors, DUT.u_collector.u_assertions.assert_fails);
    if (aborted || frames == 0 || chk.errors != 0 ||
        DUT.u_collector.u_assertions.assert_fails != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

/* tests/hand_tracker_tests.txt */
# name cr_min cb_min | red: color x0 y0 x1 y1 | blue: color x0 y0 x1 y1 | exp cr hand_x hand_y
#   cb hand_x hand_y | pulses ; x1 < x0 marks an absent rectangle, coordinates in decimal
# bounds 12 12: f800 passes cr only, 001f passes cb only, black and dark noise pass neither
# bounds 13 13: dim 8000 and 0010 (chroma nibble 12) pass neither
reset_idle        12 12 f800  1  1  0  0 001f  1  1  0  0   0  0  0  0 0
both_present      12 12 f800  2  3  9 10 001f 20 10 27 17   6  5 13 23 1
blue_absent       12 12 f800  4  4  7  7 001f  1  1  0  0   6  5 13 23 0
both_after_absent 12 12 f800 10  2 15  5 001f 16 16 30 22   3 12 19 23 1
high_bounds       13 13 8000  2  2 12 12 0010 18  8 28 20   3 12 19 23 0
moving_a          12 12 f800  1  1  6  6 001f 24  1 31  8   3  3  4 27 1
moving_b          12 12 f800  5  6 10 11 001f 20  6 27 13   8  7  9 23 1
moving_c          12 12 f800  9 12 14 19 001f 16 14 23 21  15 11 17 19 1
